//--- sim.f
+incdir+hw
hw/spi_reg_pkg.sv
hw/spi_frame_if.sv
hw/cmd_dispatch.sv
hw/reg_bank.sv
hw/rsp_collect.sv
hw/spi_reg_top.sv
verif/tb_spi_reg_top.sv

//--- verif/tb_spi_reg_top.sv
// directed testbench for spi_reg_top, bit-bangs spi frames and checks responses against a register model
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module tb_spi_reg_top;
	import spi_reg_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        spi_sck;
	logic        spi_cs_n;
	logic        spi_mosi;
	logic        spi_miso;
	// expected contents of every register, index is addr[9:0]
	logic [15:0] model [1024];
	integer      seed;
	int          errors;
	int          checks;

	spi_reg_top uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.spi_sck  (spi_sck),
		.spi_cs_n (spi_cs_n),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// frame helpers
	// ----------------------------------------------------------------------
	// header word then four bytes, bit 8 of each payload word is zero
	function automatic logic [44:0] make_frame(input logic [8:0] hdr, input logic [31:0] w);
		return {hdr, 1'b0, w[31:24], 1'b0, w[23:16], 1'b0, w[15:8], 1'b0, w[7:0]};
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_rsp(input logic [44:0] rx, input logic [8:0] hdr, input logic [31:0] pay);
		check_val("rsp header", rx[44:36], hdr);
		check_val("rsp word bit 8", {rx[35], rx[26], rx[17], rx[8]}, 4'b0000);
		check_val("rsp payload", {rx[34:27], rx[25:18], rx[16:9], rx[7:0]}, pay);
	endtask

	// ----------------------------------------------------------------------
	// spi driver, 8 clk cycles per bit, msb first
	// ----------------------------------------------------------------------
	task automatic spi_frame(input logic [44:0] tx, output logic [44:0] rx);
		rx = '0;
		@(negedge clk);
		spi_cs_n = 1'b0;
		// let the dut load its transmit register
		repeat (4) @(negedge clk);
		for (int i = 44; i >= 0; i--)
		begin
			spi_mosi = tx[i];
			repeat (4) @(negedge clk);
			// miso settled since the last sck fall
			rx = {rx[43:0], spi_miso};
			spi_sck = 1'b1;
			repeat (4) @(negedge clk);
			spi_sck = 1'b0;
		end
		repeat (4) @(negedge clk);
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	// fetch frames until a header shows up
	task automatic spi_fetch(output logic [44:0] rx);
		int   tries;
		logic done;
		tries = 0;
		done  = 1'b0;
		rx    = '0;
		while (!done && tries < 8)
		begin
			repeat (4) @(negedge clk);
			spi_frame('0, rx);
			tries++;
			if (rx[44:36] != 9'h000)
				done = 1'b1;
		end
		if (!done)
		begin
			errors++;
			$display("fetch timed out, header still zero after %0d fetch frames", tries);
		end
	endtask

	// write, model update, then the echo of address and new value
	task automatic spi_write(input logic [15:0] addr, input logic [15:0] data);
		logic [44:0] rx;
		logic [9:0]  idx;
		idx = addr[9:0];
		spi_frame(make_frame(`CMD_WR_HDR, {addr, data}), rx);
		// register 0 is read-only
		if (idx[7:0] != 8'h00)
			model[idx] = data;
		spi_fetch(rx);
		check_rsp(rx, `RSP_OK_HDR, {addr, model[idx]});
	endtask

	task automatic spi_read(input logic [15:0] addr);
		logic [44:0] rx;
		spi_frame(make_frame(`CMD_RD_HDR, {addr, 16'h0000}), rx);
		spi_fetch(rx);
		check_rsp(rx, `RSP_OK_HDR, {addr, model[addr[9:0]]});
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_bank_rw();
		logic [31:0] r;
		logic [15:0] addr;
		for (int b = 0; b < `NUM_BANKS; b++)
		begin
			r    = $random(seed);
			addr = {6'd0, 2'(b), 8'h20 + 8'(b)};
			spi_write(addr, r[15:0]);
			spi_read(addr);
		end
	endtask

	// reg 0 keeps the bank id whatever is written
	task automatic test_reg0_readonly();
		logic [31:0] r;
		logic [15:0] addr;
		for (int b = 0; b < `NUM_BANKS; b++)
		begin
			r    = $random(seed);
			addr = {6'd0, 2'(b), 8'h00};
			spi_write(addr, r[15:0]);
			spi_read(addr);
		end
	endtask

	task automatic test_bad_page();
		logic [44:0] rx;
		logic [31:0] r;
		logic [15:0] addr;
		r    = $random(seed);
		addr = {6'h15, 2'd2, 8'h20};
		spi_frame(make_frame(`CMD_WR_HDR, {addr, r[15:0]}), rx);
		spi_fetch(rx);
		check_rsp(rx, `RSP_ERR_HDR, {addr, 8'(err_bad_page), 8'h00});
		// same register without page bits, must be untouched
		spi_read({6'd0, addr[9:0]});
	endtask

	task automatic test_bad_header();
		logic [44:0] rx;
		logic [31:0] r;
		r = $random(seed);
		spi_frame(make_frame(9'h155, r), rx);
		spi_fetch(rx);
		check_rsp(rx, `RSP_ERR_HDR, {16'h0000, 8'(err_bad_header), 8'h00});
	endtask

	// fetch right behind the command, response not built yet
	task automatic test_early_fetch();
		logic [44:0] rx;
		logic [31:0] r;
		logic [15:0] addr;
		r    = $random(seed);
		addr = {6'd0, 2'd3, 8'h5A};
		spi_frame(make_frame(`CMD_WR_HDR, {addr, r[15:0]}), rx);
		model[addr[9:0]] = r[15:0];
		spi_frame('0, rx);
		check_val("early fetch header", rx[44:36], 9'h000);
		// response must still be there
		spi_fetch(rx);
		check_rsp(rx, `RSP_OK_HDR, {addr, model[addr[9:0]]});
	endtask

	task automatic test_random_pairs();
		logic [31:0] r;
		logic [31:0] d;
		logic [15:0] addr;
		for (int n = 0; n < 40; n++)
		begin
			r    = $random(seed);
			d    = $random(seed);
			addr = {6'd0, r[9:0]};
			spi_write(addr, d[15:0]);
			spi_read(addr);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		spi_sck  = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		seed     = 20;
		errors   = 0;
		checks   = 0;
		// registers reset to zero, reg 0 of each bank reads its index
		for (int i = 0; i < 1024; i++)
			model[i] = (i % 256 == 0) ? 16'(i / 256) : 16'h0000;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		repeat (4) @(negedge clk);

		test_bank_rw();
		test_reg0_readonly();
		test_bad_page();
		test_bad_header();
		test_early_fetch();
		test_random_pairs();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- hw/spi_reg_top.sv
// top of the spi register block, wires the spi front end, dispatcher, banks and collector
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module spi_reg_top (
	input  logic clk,
	input  logic arst_n,
	input  logic spi_sck,
	input  logic spi_cs_n,
	input  logic spi_mosi,
	output logic spi_miso
);
	import spi_reg_pkg::*;

	// ----------------------------------------------------------------------
	// interconnect
	// ----------------------------------------------------------------------
	reg_cmd_t              cmd;
	logic                  cmd_valid;
	logic                  hdr_err;
	reg_cmd_t              bank_cmd [`NUM_BANKS];
	logic [`NUM_BANKS-1:0] bank_cmd_valid;
	logic [`NUM_BANKS-1:0] credit_return;
	reg_rsp_t              bank_rsp [`NUM_BANKS];
	logic [`NUM_BANKS-1:0] bank_rsp_valid;
	logic [`NUM_BANKS-1:0] rsp_grant;
	reg_rsp_t              err_rsp;
	logic                  err_rsp_valid;
	logic                  err_grant;
	reg_rsp_t              rsp;
	logic                  rsp_valid;
	logic                  rsp_taken;

	spi_frame_if u_frame (
		.clk       (clk),
		.arst_n    (arst_n),
		.spi_sck   (spi_sck),
		.spi_cs_n  (spi_cs_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_taken (rsp_taken),
		.hdr_err   (hdr_err)
	);

	cmd_dispatch u_dispatch (
		.clk            (clk),
		.arst_n         (arst_n),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.hdr_err        (hdr_err),
		.bank_cmd       (bank_cmd),
		.bank_cmd_valid (bank_cmd_valid),
		.credit_return  (credit_return),
		.err_rsp        (err_rsp),
		.err_rsp_valid  (err_rsp_valid),
		.err_grant      (err_grant)
	);

	// bank id equals its index
	for (genvar i = 0; i < `NUM_BANKS; i++)
	begin : g_bank
		reg_bank #(
			.BANK_ID (i)
		) u_bank (
			.clk            (clk),
			.arst_n         (arst_n),
			.bank_cmd       (bank_cmd[i]),
			.bank_cmd_valid (bank_cmd_valid[i]),
			.credit_return  (credit_return[i]),
			.bank_rsp       (bank_rsp[i]),
			.bank_rsp_valid (bank_rsp_valid[i]),
			.rsp_grant      (rsp_grant[i])
		);
	end

	rsp_collect u_collect (
		.clk            (clk),
		.arst_n         (arst_n),
		.bank_rsp       (bank_rsp),
		.bank_rsp_valid (bank_rsp_valid),
		.rsp_grant      (rsp_grant),
		.err_rsp        (err_rsp),
		.err_rsp_valid  (err_rsp_valid),
		.err_grant      (err_grant),
		.rsp            (rsp),
		.rsp_valid      (rsp_valid),
		.rsp_taken      (rsp_taken)
	);

endmodule

//--- hw/rsp_collect.sv
// response collector, round-robin over the banks and the error source into one output buffer
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module rsp_collect (
	input  logic                  clk,
	input  logic                  arst_n,
	input  spi_reg_pkg::reg_rsp_t bank_rsp [`NUM_BANKS],
	input  logic [`NUM_BANKS-1:0] bank_rsp_valid,
	output logic [`NUM_BANKS-1:0] rsp_grant,
	input  spi_reg_pkg::reg_rsp_t err_rsp,
	input  logic                  err_rsp_valid,
	output logic                  err_grant,
	output spi_reg_pkg::reg_rsp_t rsp,
	output logic                  rsp_valid,
	input  logic                  rsp_taken
);
	import spi_reg_pkg::*;

	// error source sits above the banks
	localparam int NREQ  = `NUM_BANKS + 1;
	localparam int IDX_W = $clog2(NREQ);

	logic [NREQ-1:0]  req;
	logic [NREQ-1:0]  gnt;
	logic [IDX_W-1:0] last;
	logic [IDX_W-1:0] win;
	logic             any_gnt;
	reg_rsp_t         src [NREQ];

	assign req = {err_rsp_valid, bank_rsp_valid};

	always_comb
	begin
		for (int i = 0; i < `NUM_BANKS; i++)
			src[i] = bank_rsp[i];
		src[`NUM_BANKS] = err_rsp;
	end

	// ----------------------------------------------------------------------
	// arbiter, search starts after the last winner
	// ----------------------------------------------------------------------
	always_comb
	begin
		int cand;
		gnt     = '0;
		win     = last;
		any_gnt = 1'b0;
		cand    = 0;
		// buffer full, nobody is granted
		if (!rsp_valid)
		begin
			for (int off = 1; off <= NREQ; off++)
			begin
				cand = (int'(last) + off) % NREQ;
				if (!any_gnt && req[cand])
				begin
					any_gnt = 1'b1;
					win     = IDX_W'(cand);
				end
			end
		end
		if (any_gnt)
			gnt[win] = 1'b1;
	end

	assign rsp_grant = gnt[`NUM_BANKS-1:0];
	assign err_grant = gnt[`NUM_BANKS];

	// ----------------------------------------------------------------------
	// output buffer, emptied by a fetch
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// bank 0 wins first
			last      <= IDX_W'(NREQ - 1);
			rsp_valid <= 1'b0;
		end
		else
		begin
			if (any_gnt)
			begin
				last      <= win;
				rsp_valid <= 1'b1;
			end
			else if (rsp_taken)
				rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (any_gnt)
			rsp <= src[win];
	end

endmodule

//--- hw/reg_bank.sv
// one register bank, queues commands, executes them on 256 registers and holds one response
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module reg_bank #(
	parameter int unsigned BANK_ID = 0
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  spi_reg_pkg::reg_cmd_t bank_cmd,
	input  logic                  bank_cmd_valid,
	output logic                  credit_return,
	output spi_reg_pkg::reg_rsp_t bank_rsp,
	output logic                  bank_rsp_valid,
	input  logic                  rsp_grant
);
	import spi_reg_pkg::*;

	localparam int PTR_W = (`BANK_CREDITS > 1) ? $clog2(`BANK_CREDITS) : 1;
	localparam int CNT_W = $clog2(`BANK_CREDITS + 1);

	reg_cmd_t         q_mem [`BANK_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_cnt;
	logic             pop;
	reg_cmd_t         stage_cmd;
	logic             stage_valid;
	logic [15:0]      regs [256];
	logic [7:0]       idx;
	logic [15:0]      rd_value;

	// wrap at queue depth
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(`BANK_CREDITS - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	// ----------------------------------------------------------------------
	// command queue, overflow prevented by dispatcher credits
	// ----------------------------------------------------------------------
	// one command in flight, wait for the response to be granted
	assign pop           = (q_cnt != '0) && !stage_valid && !bank_rsp_valid;
	assign credit_return = pop;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt  <= '0;
		end
		else
		begin
			if (bank_cmd_valid)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			q_cnt <= q_cnt + CNT_W'(bank_cmd_valid) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (bank_cmd_valid)
			q_mem[wr_ptr] <= bank_cmd;
		if (pop)
			stage_cmd <= q_mem[rd_ptr];
	end

	// ----------------------------------------------------------------------
	// execute stage
	// ----------------------------------------------------------------------
	assign idx = stage_cmd.addr[7:0];

	// value after the write, reg 0 is the bank id
	always_comb
	begin
		if (idx == 8'd0)
			rd_value = 16'(BANK_ID);
		else if (stage_cmd.wr)
			rd_value = stage_cmd.data;
		else
			rd_value = regs[idx];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 256; i++)
				regs[i] <= 16'h0000;
		end
		else if (stage_valid && stage_cmd.wr && idx != 8'd0)
			regs[idx] <= stage_cmd.data;
	end

	// ----------------------------------------------------------------------
	// response holding register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage_valid    <= 1'b0;
			bank_rsp_valid <= 1'b0;
		end
		else
		begin
			stage_valid <= pop;
			if (stage_valid)
				bank_rsp_valid <= 1'b1;
			else if (rsp_grant)
				bank_rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (stage_valid)
		begin
			bank_rsp.err                 <= 1'b0;
			bank_rsp.payload.data_v.addr  <= stage_cmd.addr;
			bank_rsp.payload.data_v.value <= rd_value;
		end
	end

endmodule

//--- hw/cmd_dispatch.sv
// command router, sends each command to its bank under credit control and raises address errors
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module cmd_dispatch (
	input  logic                   clk,
	input  logic                   arst_n,
	input  spi_reg_pkg::reg_cmd_t  cmd,
	input  logic                   cmd_valid,
	input  logic                   hdr_err,
	output spi_reg_pkg::reg_cmd_t  bank_cmd [`NUM_BANKS],
	output logic [`NUM_BANKS-1:0]  bank_cmd_valid,
	input  logic [`NUM_BANKS-1:0]  credit_return,
	output spi_reg_pkg::reg_rsp_t  err_rsp,
	output logic                   err_rsp_valid,
	input  logic                   err_grant
);
	import spi_reg_pkg::*;

	localparam int CRD_W = $clog2(`BANK_CREDITS + 1);

	logic [CRD_W-1:0]      credit [`NUM_BANKS];
	reg_cmd_t              hold_cmd;
	logic                  hold_valid;
	reg_cmd_t              out_cmd;
	logic [1:0]            in_sel;
	logic [1:0]            hold_sel;
	logic                  in_bad;
	logic                  in_go;
	logic                  hold_go;
	logic [`NUM_BANKS-1:0] send;

	// bank select from address bits 9:8
	assign in_sel   = cmd.addr[9:8];
	assign hold_sel = hold_cmd.addr[9:8];
	// page bits set, or a bank that is not built
	assign in_bad   = (cmd.addr[15:10] != 6'd0) || (int'(in_sel) >= `NUM_BANKS);

	// held command has priority over a new one
	assign hold_go = hold_valid && (credit[hold_sel] != '0);
	assign in_go   = cmd_valid && !in_bad && !hold_valid && (credit[in_sel] != '0);

	always_comb
	begin
		send = '0;
		if (hold_go)
			send[hold_sel] = 1'b1;
		else if (in_go)
			send[in_sel] = 1'b1;
	end

	// ----------------------------------------------------------------------
	// credits and holding register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `NUM_BANKS; i++)
				credit[i] <= CRD_W'(`BANK_CREDITS);
			hold_valid     <= 1'b0;
			bank_cmd_valid <= '0;
		end
		else
		begin
			for (int i = 0; i < `NUM_BANKS; i++)
				credit[i] <= credit[i] - CRD_W'(send[i]) + CRD_W'(credit_return[i]);
			bank_cmd_valid <= send;
			// no credit for the new command, park it
			if (cmd_valid && !in_bad && !in_go)
				hold_valid <= 1'b1;
			else if (hold_go)
				hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_valid && !in_bad && !in_go)
			hold_cmd <= cmd;
		if (hold_go)
			out_cmd <= hold_cmd;
		else if (in_go)
			out_cmd <= cmd;
	end

	// one data register fans out, valid picks the bank
	always_comb
	begin
		for (int i = 0; i < `NUM_BANKS; i++)
			bank_cmd[i] = out_cmd;
	end

	// ----------------------------------------------------------------------
	// error responses
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			err_rsp_valid <= 1'b0;
		else if (hdr_err || (cmd_valid && in_bad))
			err_rsp_valid <= 1'b1;
		else if (err_grant)
			err_rsp_valid <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (hdr_err)
		begin
			err_rsp.err                  <= 1'b1;
			// no address in a bad frame
			err_rsp.payload.err_v.bad_addr <= 16'h0000;
			err_rsp.payload.err_v.code     <= err_bad_header;
			err_rsp.payload.err_v.rsvd     <= 8'h00;
		end
		else if (cmd_valid && in_bad)
		begin
			err_rsp.err                  <= 1'b1;
			err_rsp.payload.err_v.bad_addr <= cmd.addr;
			err_rsp.payload.err_v.code     <= err_bad_page;
			err_rsp.payload.err_v.rsvd     <= 8'h00;
		end
	end

endmodule

//--- hw/spi_frame_if.sv
// spi slave front end, oversamples the host bus in the clk domain and turns frames into commands
`timescale 1ns/1ps
`include "spi_reg_macros.svh"

module spi_frame_if (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  spi_sck,
	input  logic                  spi_cs_n,
	input  logic                  spi_mosi,
	output logic                  spi_miso,
	output spi_reg_pkg::reg_cmd_t cmd,
	output logic                  cmd_valid,
	input  spi_reg_pkg::reg_rsp_t rsp,
	input  logic                  rsp_valid,
	output logic                  rsp_taken,
	output logic                  hdr_err
);
	import spi_reg_pkg::*;

	// two sync stages plus one for edge detect
	logic [2:0]             sck_sr;
	logic [2:0]             cs_sr;
	logic [1:0]             mosi_sr;
	logic                   sck_rise;
	logic                   sck_fall;
	logic                   cs_rise;
	logic                   cs_fall;
	logic                   cs_act;
	logic                   mosi_s;
	logic [`FRAME_BITS-1:0] rx_sr;
	logic [`FRAME_BITS-1:0] tx_sr;
	logic [`FRAME_BITS-1:0] tx_frame;
	logic [8:0]             rx_hdr;
	logic [8:0]             tx_hdr;
	logic [5:0]             bit_cnt;
	// response was ready when the frame began
	logic                   load_valid;

	// ----------------------------------------------------------------------
	// input synchronizers and edge detect
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sck_sr  <= '0;
			cs_sr   <= '1;
			mosi_sr <= '0;
		end
		else
		begin
			sck_sr  <= {sck_sr[1:0], spi_sck};
			cs_sr   <= {cs_sr[1:0], spi_cs_n};
			mosi_sr <= {mosi_sr[0], spi_mosi};
		end
	end

	assign sck_rise = sck_sr[1] & ~sck_sr[2];
	assign sck_fall = ~sck_sr[1] & sck_sr[2];
	assign cs_rise  = cs_sr[1] & ~cs_sr[2];
	assign cs_fall  = ~cs_sr[1] & cs_sr[2];
	assign cs_act   = ~cs_sr[1];
	assign mosi_s   = mosi_sr[1];

	// ----------------------------------------------------------------------
	// receive path, msb first on sck rising
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (sck_rise && cs_act)
			rx_sr <= {rx_sr[`FRAME_BITS-2:0], mosi_s};
	end

	assign rx_hdr = rx_sr[`FRAME_BITS-1 -: 9];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_cnt    <= '0;
			load_valid <= 1'b0;
			rsp_taken  <= 1'b0;
			cmd_valid  <= 1'b0;
			hdr_err    <= 1'b0;
		end
		else
		begin
			rsp_taken <= 1'b0;
			cmd_valid <= 1'b0;
			hdr_err   <= 1'b0;
			if (cs_fall)
			begin
				bit_cnt    <= '0;
				load_valid <= rsp_valid;
			end
			else if (sck_rise && cs_act)
			begin
				// saturate on overlong frames
				if (bit_cnt != '1)
					bit_cnt <= bit_cnt + 6'd1;
				// ninth bit completes the header, zero header is a fetch
				if (bit_cnt == 6'd8 && rx_sr[7:0] == 8'h00 && !mosi_s && load_valid)
				begin
					rsp_taken  <= 1'b1;
					load_valid <= 1'b0;
				end
			end
			// wrong length frames are dropped
			if (cs_rise && bit_cnt == 6'(`FRAME_BITS))
			begin
				case (rx_hdr)
					`CMD_WR_HDR,
					`CMD_RD_HDR: cmd_valid <= 1'b1;
					9'h000:      ;
					default:     hdr_err <= 1'b1;
				endcase
			end
		end
	end

	// command fields, bit 8 of each word is dropped
	always_ff @(posedge clk)
	begin
		if (cs_rise)
		begin
			cmd.wr   <= (rx_hdr == `CMD_WR_HDR);
			cmd.addr <= {rx_sr[34:27], rx_sr[25:18]};
			cmd.data <= {rx_sr[16:9], rx_sr[7:0]};
		end
	end

	// ----------------------------------------------------------------------
	// transmit path, loaded at cs_n fall, shifted on sck falling
	// ----------------------------------------------------------------------
	assign tx_hdr   = rsp.err ? `RSP_ERR_HDR : `RSP_OK_HDR;
	assign tx_frame = {tx_hdr,
		1'b0, rsp.payload[31:24], 1'b0, rsp.payload[23:16],
		1'b0, rsp.payload[15:8], 1'b0, rsp.payload[7:0]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			tx_sr <= '0;
		else if (cs_fall)
			// nothing ready, all zero frame
			tx_sr <= rsp_valid ? tx_frame : '0;
		else if (sck_fall && cs_act)
			tx_sr <= {tx_sr[`FRAME_BITS-2:0], 1'b0};
	end

	assign spi_miso = tx_sr[`FRAME_BITS-1];

endmodule

//--- hw/spi_reg_pkg.sv
// shared command and response types for the spi register block, imported by every rtl module
package spi_reg_pkg;

	// ----------------------------------------------------------------------
	// error codes carried in the error view of a response
	// ----------------------------------------------------------------------
	typedef enum logic [7:0] {
		err_bad_page   = 8'h01,
		err_bad_header = 8'h02
	} err_code_e;

	// ----------------------------------------------------------------------
	// command from the spi side, one per command frame
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic        wr;
		logic [15:0] addr;
		logic [15:0] data;
	} reg_cmd_t;

	// normal answer, address echo plus register value
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] value;
	} rsp_data_t;

	// error answer, offending address plus reason
	typedef struct packed {
		logic [15:0] bad_addr;
		err_code_e   code;
		logic [7:0]  rsvd;
	} rsp_error_t;

	// one 32 bit payload word, view picked by the err flag
	typedef union packed {
		rsp_data_t  data_v;
		rsp_error_t err_v;
	} rsp_payload_u;

	typedef struct packed {
		logic         err;
		rsp_payload_u payload;
	} reg_rsp_t;

endpackage

//--- hw/spi_reg_macros.svh
// global constants of the spi register block, include before any module that sizes ports with them
`ifndef SPI_REG_MACROS_SVH
`define SPI_REG_MACROS_SVH

// number of banks, address bits 9:8 pick one
// power of two, 4 at most
`define NUM_BANKS 4

// command queue depth per bank
// also the starting credit count in the dispatcher
`define BANK_CREDITS 2

// command frame headers
`define CMD_WR_HDR 9'h180
`define CMD_RD_HDR 9'h181

// response frame headers
`define RSP_OK_HDR 9'h1A0
`define RSP_ERR_HDR 9'h1A1

// five 9 bit words per frame
`define FRAME_BITS 45

`endif
